// ==== common/motor_regs_config.svh ====
// ####################
// Motor register block configuration
// Bus widths, channel counts and the host address map
// ####################
`ifndef MOTOR_REGS_CONFIG_SVH
`define MOTOR_REGS_CONFIG_SVH

// Host bus
`define MR_ADDR_WIDTH       6
`define MR_DATA_WIDTH       8

// Motor field widths
`define MR_ANGLE_WIDTH      12
`define MR_ANGLE_HI_WIDTH   (`MR_ANGLE_WIDTH - `MR_DATA_WIDTH)  // Nibble above the low byte
`define MR_PWM_WIDTH        5
`define MR_TEMP_WIDTH       6

// Channel counts
`define MR_NUM_DRIVE        4
`define MR_NUM_ROT          2

// Broadcast write addresses, 0x00 is reserved
`define MR_ADDR_BCAST_ALL   'h01   // Every control register
`define MR_ADDR_BCAST_ROT   'h02   // Rotation controls only
`define MR_ADDR_BCAST_DRIVE 'h03   // Drive controls only

// Drive n: control at base+2n, status at base+2n+1
`define MR_ADDR_DRIVE_BASE  'h04
`define MR_DRIVE_STRIDE     2

// Rotation m: control, target low, snapshot low, cmd/status from base+4m
`define MR_ADDR_ROT_BASE    'h10
`define MR_ROT_STRIDE       4

`endif

// ==== common/motor_regs_pkg.sv ====
// ####################
// Motor register types
// Bus word, control fields and the rotation cmd/status word
// ####################
`include "motor_regs_config.svh"

package motor_regs_pkg;

    typedef logic [`MR_DATA_WIDTH-1:0] data_word_t;  // One host bus byte

    // Same layout for drive and rotation control registers
    typedef struct packed {
        logic                     brake;      // Bit 7
        logic                     enable;     // Bit 6
        logic                     direction;  // Bit 5
        logic [`MR_PWM_WIDTH-1:0] low;        // PWM level, or {0, angle high nibble}
    } motor_ctrl_t;

    // Written byte at the cmd/status address
    typedef struct packed {
        logic       rsvd;       // Ignored
        logic       snapshot;   // Capture current angle
        logic       update;     // Start move to target
        logic       abort;      // Stop move
        logic [3:0] rsvd_lo;    // Ignored
    } rot_cmd_t;

    // Read byte at the same address
    typedef struct packed {
        logic                          angle_done;
        logic [2:0]                    zero;
        logic [`MR_ANGLE_HI_WIDTH-1:0] snap_hi;     // Upper bits of snapshot
    } rot_stat_t;

    typedef union packed {
        rot_cmd_t  cmd;     // Write view
        rot_stat_t stat;    // Read view
    } rot_cmd_stat_t;

endpackage

// ==== drive/drive_channel.sv ====
// ####################
// Drive motor channel
// Control register and sampled status register
// ####################
`timescale 1ns/1ns
`include "motor_regs_config.svh"

module drive_channel import motor_regs_pkg::*; (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      ctrl_wr,        // From decoder, broadcast included
    input  data_word_t                wr_data,
    input  logic                      fault,
    input  logic                      startup_fail,
    input  logic [`MR_TEMP_WIDTH-1:0] adc_temp,
    output logic                      brake,
    output logic                      enable,
    output logic                      direction,
    output logic [`MR_PWM_WIDTH-1:0]  pwm,
    output data_word_t                ctrl_q,
    output data_word_t                status_q        // {fault, startup_fail, adc_temp}
);
    motor_ctrl_t ctrl_r;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_r <= '0;       // Motor off, brake released
        end else if (ctrl_wr) begin
            ctrl_r <= motor_ctrl_t'(wr_data);
        end
    end

    // Sampled every edge, a read sees the previous edge
    always_ff @(posedge clock) begin
        status_q <= {fault, startup_fail, adc_temp};
    end

    assign brake     = ctrl_r.brake;
    assign enable    = ctrl_r.enable;
    assign direction = ctrl_r.direction;
    assign pwm       = ctrl_r.low;      // Full low field is PWM
    assign ctrl_q    = ctrl_r;          // Reads back as written

    // Motor pins and read words stay known once out of reset
    ap_known: assert property (@(posedge clock) disable iff (!rst_n)
        !$isunknown({brake, enable, direction, pwm, ctrl_q, status_q}));

endmodule

// ==== rotation/rotation_channel.sv ====
// ####################
// Steering rotation channel
// Target angle, angle snapshot, update/abort pulses
// ####################
`timescale 1ns/1ns
`include "motor_regs_config.svh"

module rotation_channel import motor_regs_pkg::*; (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       ctrl_wr,
    input  logic                       target_wr,
    input  logic                       cmd_wr,
    input  data_word_t                 wr_data,
    input  logic [`MR_ANGLE_WIDTH-1:0] current_angle,  // From angle sensor
    input  logic                       angle_done,
    output logic                       brake,
    output logic                       enable,
    output logic                       direction,
    output logic [`MR_ANGLE_WIDTH-1:0] target_angle,
    output logic                       update_angle,   // One cycle pulse
    output logic                       abort_angle,    // One cycle pulse
    output data_word_t                 ctrl_q,
    output data_word_t                 target_q,
    output data_word_t                 snap_q,
    output data_word_t                 stat_q
);
    motor_ctrl_t                ctrl_in;        // Written byte, bit 4 forced low
    motor_ctrl_t                ctrl_r;
    data_word_t                 target_lo_r;
    logic [`MR_ANGLE_WIDTH-1:0] snap_r;
    rot_cmd_stat_t              cmd_w;
    rot_cmd_stat_t              stat_w;

    assign cmd_w = wr_data;     // Command view of the bus byte

    always_comb begin
        ctrl_in                       = motor_ctrl_t'(wr_data);
        ctrl_in.low[`MR_PWM_WIDTH-1]  = 1'b0;   // Unused for rotation
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_r      <= '0;
            target_lo_r <= '0;
        end else begin
            if (ctrl_wr)
                ctrl_r <= ctrl_in;
            if (target_wr)
                target_lo_r <= wr_data;
        end
    end

    // Command decode, pulses only last the cycle after the write
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            update_angle <= 1'b0;
            abort_angle  <= 1'b0;
            snap_r       <= '0;
        end else begin
            update_angle <= cmd_wr & cmd_w.cmd.update;
            abort_angle  <= cmd_wr & cmd_w.cmd.abort;
            if (cmd_wr && cmd_w.cmd.snapshot)
                snap_r <= current_angle;    // Frozen so both halves match
        end
    end

    // Status byte, angle_done is live
    always_comb begin
        stat_w                 = '0;
        stat_w.stat.angle_done = angle_done;
        stat_w.stat.snap_hi    = snap_r[`MR_ANGLE_WIDTH-1:`MR_DATA_WIDTH];
    end

    assign brake        = ctrl_r.brake;
    assign enable       = ctrl_r.enable;
    assign direction    = ctrl_r.direction;
    assign target_angle = {ctrl_r.low[`MR_ANGLE_HI_WIDTH-1:0], target_lo_r};
    assign ctrl_q       = ctrl_r;
    assign target_q     = target_lo_r;
    assign snap_q       = snap_r[`MR_DATA_WIDTH-1:0];
    assign stat_q       = stat_w;

    // Host accesses are spaced, so a pulse never repeats back to back
    ap_update_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        update_angle |=> !update_angle);
    ap_abort_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        abort_angle |=> !abort_angle);

endmodule

// ==== verification/motor_regs_tb.sv ====
// ####################
// Motor register block testbench
// Bus stimulus, reference model, concurrent checks on every edge
// ####################
`timescale 1ns/1ns
`include "motor_regs_config.svh"

module motor_regs_tb import motor_regs_pkg::*; ();
    logic                           clock;
    logic                           rst_n;
    logic [`MR_ADDR_WIDTH-1:0]      address;
    logic                           write_en;
    logic                           read_en;
    data_word_t                     wr_data;
    data_word_t                     rd_data;
    logic [3:0]                     fault_in, startup_fail_in;
    logic [3:0][`MR_TEMP_WIDTH-1:0] temp_in;
    logic [1:0][`MR_ANGLE_WIDTH-1:0] angle_in;
    logic [1:0]                     angle_done_in;
    logic [3:0][7:0]                drive_out;      // {brake, enable, direction, pwm}
    logic [1:0][16:0]               rot_out;        // {brake, en, dir, target, upd, abort}
    logic [1:0]                     upd_out, abt_out;

    // Reference model state
    data_word_t [3:0]                exp_drive, exp_status;
    data_word_t [1:0]                exp_rot_ctrl, exp_rot_lo;
    logic [1:0][`MR_ANGLE_WIDTH-1:0] exp_snap;
    logic [1:0]                      exp_upd, exp_abt;
    data_word_t                      exp_rd;
    rot_cmd_stat_t                   model_cmd;     // Command view of wr_data
    logic [31:0]                     rng;
    string                           test_name;

    tb_clock_gen u_clock_gen (.clock(clock), .rst_n(rst_n));

    motor_regs_top u_motor_regs_top (
        .clock(clock), .rst_n(rst_n), .address(address), .write_en(write_en),
        .wr_data(wr_data), .read_en(read_en), .rd_data(rd_data),
        .fault0(fault_in[0]), .fault1(fault_in[1]),
        .fault2(fault_in[2]), .fault3(fault_in[3]),
        .startup_fail0(startup_fail_in[0]), .startup_fail1(startup_fail_in[1]),
        .startup_fail2(startup_fail_in[2]), .startup_fail3(startup_fail_in[3]),
        .adc_temp0(temp_in[0]), .adc_temp1(temp_in[1]),
        .adc_temp2(temp_in[2]), .adc_temp3(temp_in[3]),
        .brake0(drive_out[0][7]), .brake1(drive_out[1][7]),
        .brake2(drive_out[2][7]), .brake3(drive_out[3][7]),
        .enable0(drive_out[0][6]), .enable1(drive_out[1][6]),
        .enable2(drive_out[2][6]), .enable3(drive_out[3][6]),
        .direction0(drive_out[0][5]), .direction1(drive_out[1][5]),
        .direction2(drive_out[2][5]), .direction3(drive_out[3][5]),
        .pwm0(drive_out[0][4:0]), .pwm1(drive_out[1][4:0]),
        .pwm2(drive_out[2][4:0]), .pwm3(drive_out[3][4:0]),
        .current_angle0(angle_in[0]), .current_angle1(angle_in[1]),
        .angle_done0(angle_done_in[0]), .angle_done1(angle_done_in[1]),
        .rot_brake0(rot_out[0][16]), .rot_brake1(rot_out[1][16]),
        .rot_enable0(rot_out[0][15]), .rot_enable1(rot_out[1][15]),
        .rot_direction0(rot_out[0][14]), .rot_direction1(rot_out[1][14]),
        .target_angle0(rot_out[0][13:2]), .target_angle1(rot_out[1][13:2]),
        .update_angle0(rot_out[0][1]), .update_angle1(rot_out[1][1]),
        .abort_angle0(rot_out[0][0]), .abort_angle1(rot_out[1][0])
    );

    assign upd_out   = {rot_out[1][1], rot_out[0][1]};
    assign abt_out   = {rot_out[1][0], rot_out[0][0]};
    assign model_cmd = wr_data;

    function automatic logic [`MR_ADDR_WIDTH-1:0] drive_reg_addr(input int n, input int off);
        return `MR_ADDR_DRIVE_BASE + 2 * n + off;
    endfunction

    function automatic logic [`MR_ADDR_WIDTH-1:0] rot_reg_addr(input int m, input int off);
        return `MR_ADDR_ROT_BASE + 4 * m + off;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Word the host should see for a read of address a
    function automatic data_word_t model_read(input logic [`MR_ADDR_WIDTH-1:0] a);
        data_word_t    word;
        rot_cmd_stat_t st;
        word = '0;                      // Unmapped and broadcast addresses
        for (int i = 0; i < 4; i++) begin
            if (a == drive_reg_addr(i, 0)) word = exp_drive[i];
            if (a == drive_reg_addr(i, 1)) word = exp_status[i];
        end
        for (int m = 0; m < 2; m++) begin
            st                 = '0;
            st.stat.angle_done = angle_done_in[m];
            st.stat.snap_hi    = exp_snap[m][11:8];
            if (a == rot_reg_addr(m, 0)) word = exp_rot_ctrl[m];
            if (a == rot_reg_addr(m, 1)) word = exp_rot_lo[m];
            if (a == rot_reg_addr(m, 2)) word = exp_snap[m][7:0];
            if (a == rot_reg_addr(m, 3)) word = st;
        end
        return word;
    endfunction

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            exp_drive    <= '0;
            exp_rot_ctrl <= '0;
            exp_rot_lo   <= '0;
            exp_snap     <= '0;
            exp_upd      <= '0;
            exp_abt      <= '0;
            exp_rd       <= '0;
        end else begin
            exp_upd <= '0;              // Pulses last one cycle
            exp_abt <= '0;
            for (int i = 0; i < 4; i++)
                if (write_en && (address == drive_reg_addr(i, 0) ||
                        address == `MR_ADDR_BCAST_ALL || address == `MR_ADDR_BCAST_DRIVE))
                    exp_drive[i] <= wr_data;
            for (int m = 0; m < 2; m++) begin
                if (write_en && (address == rot_reg_addr(m, 0) ||
                        address == `MR_ADDR_BCAST_ALL || address == `MR_ADDR_BCAST_ROT))
                    exp_rot_ctrl[m] <= wr_data & 8'hef;     // Bit 4 unused
                if (write_en && address == rot_reg_addr(m, 1))
                    exp_rot_lo[m] <= wr_data;
                if (write_en && address == rot_reg_addr(m, 3)) begin
                    exp_upd[m] <= model_cmd.cmd.update;
                    exp_abt[m] <= model_cmd.cmd.abort;
                    if (model_cmd.cmd.snapshot)
                        exp_snap[m] <= angle_in[m];
                end
            end
            if (read_en)
                exp_rd <= model_read(address);
        end
    end

    // Status registers sample on every edge
    always @(posedge clock)
        for (int i = 0; i < 4; i++)
            exp_status[i] <= {fault_in[i], startup_fail_in[i], temp_in[i]};

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_on_error($sformatf("CHECK FAILED %s (%s): expected 0x%0h actual 0x%0h",
                                test_name, what, expected, actual));
    endtask

    for (genvar i = 0; i < 4; i++) begin : g_drive_chk
        ap_drive: assert property (@(posedge clock) disable iff (!rst_n)
            drive_out[i] == exp_drive[i])
            else report_mismatch($sformatf("drive %0d outputs", i),
                                 $sampled(exp_drive[i]), $sampled(drive_out[i]));
    end

    for (genvar m = 0; m < 2; m++) begin : g_rot_chk
        ap_rot: assert property (@(posedge clock) disable iff (!rst_n)
            rot_out[m] == {exp_rot_ctrl[m][7:5], exp_rot_ctrl[m][3:0], exp_rot_lo[m],
                           exp_upd[m], exp_abt[m]})
            else report_mismatch($sformatf("rotation %0d outputs", m),
                $sampled({exp_rot_ctrl[m][7:5], exp_rot_ctrl[m][3:0], exp_rot_lo[m],
                          exp_upd[m], exp_abt[m]}), $sampled(rot_out[m]));
    end

    ap_read: assert property (@(posedge clock) disable iff (!rst_n) rd_data == exp_rd)
        else report_mismatch("read data", $sampled(exp_rd), $sampled(rd_data));

    task automatic step();
        @(posedge clock);
        #2;                             // Inputs change after the edge
    endtask

    task automatic bus_write(input logic [`MR_ADDR_WIDTH-1:0] a, input data_word_t d);
        address  = a;
        wr_data  = d;
        write_en = 1'b1;
        step();
        write_en = 1'b0;
    endtask

    task automatic bus_read(input logic [`MR_ADDR_WIDTH-1:0] a);
        address = a;
        read_en = 1'b1;
        step();
        read_en = 1'b0;
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (!rst_n) begin
            if (cycles == 20)
                stop_on_error("Timeout: reset was never released");
            cycles++;
            @(posedge clock);
        end
        step();
    endtask

    task automatic wait_for_pulse(input int m, input bit is_update);
        int cycles;
        cycles = 0;
        while (!(is_update ? upd_out[m] : abt_out[m])) begin
            if (cycles == 5)
                stop_on_error($sformatf("Timeout: no pulse on rotation channel %0d", m));
            cycles++;
            step();
        end
    endtask

    initial begin
        data_word_t d;
        address         = '0;
        write_en        = 1'b0;
        read_en         = 1'b0;
        wr_data         = '0;
        fault_in        = '0;
        startup_fail_in = '0;
        temp_in         = '0;
        angle_in        = '0;
        angle_done_in   = '0;
        rng             = 32'h6097_f2a2;
        test_name       = "reset";
        wait_for_reset();
        for (int a = 1; a < 'h18; a++)
            bus_read(a);                // Maps, broadcasts and holes

        test_name = "drive control";
        for (int i = 0; i < 4; i++) begin
            d = next_rand();
            bus_write(drive_reg_addr(i, 0), d);
            bus_read(drive_reg_addr(i, 0));
        end

        test_name = "broadcast";
        bus_write(`MR_ADDR_BCAST_DRIVE, next_rand());
        bus_write(`MR_ADDR_BCAST_ROT, next_rand());
        bus_read(rot_reg_addr(1, 0));
        bus_write(`MR_ADDR_BCAST_ALL, next_rand());
        bus_read(drive_reg_addr(3, 0));

        test_name = "drive status";
        for (int i = 0; i < 4; i++) begin
            {fault_in[i], startup_fail_in[i], temp_in[i]} = next_rand();
            step();
            bus_read(drive_reg_addr(i, 1));
            temp_in[i] = next_rand();   // Change just after the sampling edge
            bus_read(drive_reg_addr(i, 1));
        end

        test_name = "rotation";
        for (int m = 0; m < 2; m++) begin
            bus_write(rot_reg_addr(m, 0), next_rand());
            bus_write(rot_reg_addr(m, 1), next_rand());
            bus_read(rot_reg_addr(m, 0));
            bus_read(rot_reg_addr(m, 1));
            bus_write(rot_reg_addr(m, 3), 8'h20);   // Update
            wait_for_pulse(m, 1'b1);
            step();                                 // Let the pulse end
            bus_write(rot_reg_addr(m, 3), 8'h10);   // Abort
            wait_for_pulse(m, 1'b0);
            step();
            bus_write(rot_reg_addr(m, 3), 8'h30);
            angle_in[m] = next_rand();
            step();
            bus_write(rot_reg_addr(m, 3), 8'h40);   // Snapshot
            angle_in[m]      = next_rand();
            angle_done_in[m] = 1'b1;
            bus_read(rot_reg_addr(m, 2));
            bus_read(rot_reg_addr(m, 3));
            angle_done_in[m] = 1'b0;
        end

        test_name = "unmapped";
        bus_write('h00, next_rand());
        bus_write('h0c, next_rand());
        bus_write('h3f, next_rand());
        bus_read('h0c);
        bus_read('h18);
        bus_read('h3f);
        repeat (3) step();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
// ####################
// Testbench clock and reset
// 20 ns clock, reset low for the first cycles
// ####################
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clock,
    output logic rst_n
);
    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2 rst_n = 1'b1;    // Released off the edge
    end

endmodule

// ==== verilog/host_decode.sv ====
// ####################
// Host address decoder
// Write strobes per register, broadcasts folded in, registered read mux
// ####################
`timescale 1ns/1ns
`include "motor_regs_config.svh"

module host_decode import motor_regs_pkg::*; (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic [`MR_ADDR_WIDTH-1:0]      address,
    input  logic                           write_en,
    input  logic                           read_en,
    output logic [`MR_NUM_DRIVE-1:0]       drive_ctrl_wr,   // Drive control strobes
    output logic [`MR_NUM_ROT-1:0]         rot_ctrl_wr,
    output logic [`MR_NUM_ROT-1:0]         rot_target_wr,
    output logic [`MR_NUM_ROT-1:0]         rot_cmd_wr,
    input  data_word_t [`MR_NUM_DRIVE-1:0] drive_ctrl_q,    // Read words from channels
    input  data_word_t [`MR_NUM_DRIVE-1:0] drive_status_q,
    input  data_word_t [`MR_NUM_ROT-1:0]   rot_ctrl_q,
    input  data_word_t [`MR_NUM_ROT-1:0]   rot_target_q,
    input  data_word_t [`MR_NUM_ROT-1:0]   rot_snap_q,
    input  data_word_t [`MR_NUM_ROT-1:0]   rot_stat_q,
    output data_word_t                     rd_data          // Holds until next read
);
    typedef logic [`MR_ADDR_WIDTH-1:0] addr_t;

    logic       bcast_all;
    logic       bcast_drive;
    logic       bcast_rot;
    data_word_t rd_mux;     // Selected word before the read register

    function automatic addr_t drive_addr(input int n, input int off);
        return addr_t'(`MR_ADDR_DRIVE_BASE + `MR_DRIVE_STRIDE * n + off);
    endfunction

    function automatic addr_t rot_addr(input int m, input int off);
        return addr_t'(`MR_ADDR_ROT_BASE + `MR_ROT_STRIDE * m + off);
    endfunction

    assign bcast_all   = (address == addr_t'(`MR_ADDR_BCAST_ALL));
    assign bcast_drive = (address == addr_t'(`MR_ADDR_BCAST_DRIVE));
    assign bcast_rot   = (address == addr_t'(`MR_ADDR_BCAST_ROT));

    // Strobes and read select, purely combinational
    always_comb begin
        drive_ctrl_wr = '0;
        rot_ctrl_wr   = '0;
        rot_target_wr = '0;
        rot_cmd_wr    = '0;
        rd_mux        = '0;     // Unmapped reads as zero
        for (int i = 0; i < `MR_NUM_DRIVE; i++) begin
            drive_ctrl_wr[i] = write_en &
                ((address == drive_addr(i, 0)) | bcast_all | bcast_drive);
            if (address == drive_addr(i, 0))
                rd_mux = drive_ctrl_q[i];
            if (address == drive_addr(i, 1))
                rd_mux = drive_status_q[i];     // Status is read only
        end
        for (int m = 0; m < `MR_NUM_ROT; m++) begin
            rot_ctrl_wr[m]   = write_en &
                ((address == rot_addr(m, 0)) | bcast_all | bcast_rot);
            rot_target_wr[m] = write_en & (address == rot_addr(m, 1));
            rot_cmd_wr[m]    = write_en & (address == rot_addr(m, 3));
            if (address == rot_addr(m, 0))
                rd_mux = rot_ctrl_q[m];
            if (address == rot_addr(m, 1))
                rd_mux = rot_target_q[m];
            if (address == rot_addr(m, 2))
                rd_mux = rot_snap_q[m];         // Snapshot low byte
            if (address == rot_addr(m, 3))
                rd_mux = rot_stat_q[m];         // Status view of cmd word
        end
    end

    // One cycle read latency
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (read_en) begin
            rd_data <= rd_mux;
        end
    end

    // Only a broadcast may hit several registers with one write
    ap_one_strobe: assert property (@(posedge clock) disable iff (!rst_n)
        !(bcast_all || bcast_drive || bcast_rot) |->
            $onehot0({drive_ctrl_wr, rot_ctrl_wr, rot_target_wr, rot_cmd_wr}));

endmodule

// ==== verilog/motor_regs_top.sv ====
// ####################
// Motor controller register block
// Host decoder, four drive and two rotation channels
// ####################
`timescale 1ns/1ns
`include "motor_regs_config.svh"

module motor_regs_top import motor_regs_pkg::*; (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic [`MR_ADDR_WIDTH-1:0]  address,
    input  logic                       write_en,
    input  data_word_t                 wr_data,
    input  logic                       read_en,
    output data_word_t                 rd_data,
    // Drive channels
    input  logic                       fault0, fault1, fault2, fault3,
    input  logic                       startup_fail0, startup_fail1,
    input  logic                       startup_fail2, startup_fail3,
    input  logic [`MR_TEMP_WIDTH-1:0]  adc_temp0, adc_temp1, adc_temp2, adc_temp3,
    output logic                       brake0, brake1, brake2, brake3,
    output logic                       enable0, enable1, enable2, enable3,
    output logic                       direction0, direction1, direction2, direction3,
    output logic [`MR_PWM_WIDTH-1:0]   pwm0, pwm1, pwm2, pwm3,
    // Rotation channels
    input  logic [`MR_ANGLE_WIDTH-1:0] current_angle0, current_angle1,
    input  logic                       angle_done0, angle_done1,
    output logic                       rot_brake0, rot_brake1,
    output logic                       rot_enable0, rot_enable1,
    output logic                       rot_direction0, rot_direction1,
    output logic [`MR_ANGLE_WIDTH-1:0] target_angle0, target_angle1,
    output logic                       update_angle0, update_angle1,
    output logic                       abort_angle0, abort_angle1
);
    localparam int ND = `MR_NUM_DRIVE;
    localparam int NR = `MR_NUM_ROT;

    logic [ND-1:0]       drive_ctrl_wr;
    logic [NR-1:0]       rot_ctrl_wr, rot_target_wr, rot_cmd_wr;
    data_word_t [ND-1:0] drive_ctrl_q, drive_status_q;
    data_word_t [NR-1:0] rot_ctrl_q, rot_target_q, rot_snap_q, rot_stat_q;

    // Channel-indexed views of the numbered pins
    logic [ND-1:0]                      fault_v, startup_fail_v;
    logic [ND-1:0]                      brake_v, enable_v, direction_v;
    logic [ND-1:0][`MR_TEMP_WIDTH-1:0]  adc_temp_v;
    logic [ND-1:0][`MR_PWM_WIDTH-1:0]   pwm_v;
    logic [NR-1:0][`MR_ANGLE_WIDTH-1:0] current_angle_v, target_angle_v;
    logic [NR-1:0]                      angle_done_v, update_v, abort_v;
    logic [NR-1:0]                      rot_brake_v, rot_enable_v, rot_direction_v;

    assign fault_v        = {fault3, fault2, fault1, fault0};
    assign startup_fail_v = {startup_fail3, startup_fail2, startup_fail1, startup_fail0};
    assign adc_temp_v     = {adc_temp3, adc_temp2, adc_temp1, adc_temp0};
    assign {brake3, brake2, brake1, brake0}                 = brake_v;
    assign {enable3, enable2, enable1, enable0}             = enable_v;
    assign {direction3, direction2, direction1, direction0} = direction_v;
    assign {pwm3, pwm2, pwm1, pwm0}                         = pwm_v;

    assign current_angle_v = {current_angle1, current_angle0};
    assign angle_done_v    = {angle_done1, angle_done0};
    assign {rot_brake1, rot_brake0}         = rot_brake_v;
    assign {rot_enable1, rot_enable0}       = rot_enable_v;
    assign {rot_direction1, rot_direction0} = rot_direction_v;
    assign {target_angle1, target_angle0}   = target_angle_v;
    assign {update_angle1, update_angle0}   = update_v;
    assign {abort_angle1, abort_angle0}     = abort_v;

    host_decode u_host_decode (
        .clock          (clock),
        .rst_n          (rst_n),
        .address        (address),
        .write_en       (write_en),
        .read_en        (read_en),
        .drive_ctrl_wr  (drive_ctrl_wr),
        .rot_ctrl_wr    (rot_ctrl_wr),
        .rot_target_wr  (rot_target_wr),
        .rot_cmd_wr     (rot_cmd_wr),
        .drive_ctrl_q   (drive_ctrl_q),
        .drive_status_q (drive_status_q),
        .rot_ctrl_q     (rot_ctrl_q),
        .rot_target_q   (rot_target_q),
        .rot_snap_q     (rot_snap_q),
        .rot_stat_q     (rot_stat_q),
        .rd_data        (rd_data)
    );

    for (genvar i = 0; i < ND; i++) begin : g_drive
        drive_channel u_drive (
            .clock        (clock),
            .rst_n        (rst_n),
            .ctrl_wr      (drive_ctrl_wr[i]),
            .wr_data      (wr_data),            // Shared by every channel
            .fault        (fault_v[i]),
            .startup_fail (startup_fail_v[i]),
            .adc_temp     (adc_temp_v[i]),
            .brake        (brake_v[i]),
            .enable       (enable_v[i]),
            .direction    (direction_v[i]),
            .pwm          (pwm_v[i]),
            .ctrl_q       (drive_ctrl_q[i]),
            .status_q     (drive_status_q[i])
        );
    end

    for (genvar m = 0; m < NR; m++) begin : g_rot
        rotation_channel u_rot (
            .clock         (clock),
            .rst_n         (rst_n),
            .ctrl_wr       (rot_ctrl_wr[m]),
            .target_wr     (rot_target_wr[m]),
            .cmd_wr        (rot_cmd_wr[m]),
            .wr_data       (wr_data),
            .current_angle (current_angle_v[m]),
            .angle_done    (angle_done_v[m]),
            .brake         (rot_brake_v[m]),
            .enable        (rot_enable_v[m]),
            .direction     (rot_direction_v[m]),
            .target_angle  (target_angle_v[m]),
            .update_angle  (update_v[m]),
            .abort_angle   (abort_v[m]),
            .ctrl_q        (rot_ctrl_q[m]),
            .target_q      (rot_target_q[m]),
            .snap_q        (rot_snap_q[m]),
            .stat_q        (rot_stat_q[m])
        );
    end

endmodule

// ==== vlog.f ====
+incdir+common
common/motor_regs_pkg.sv
verilog/host_decode.sv
drive/drive_channel.sv
rotation/rotation_channel.sv
verilog/motor_regs_top.sv
verification/tb_clock_gen.sv
verification/motor_regs_tb.sv
